/* tb.f */
+incdir+hdl
hdl/jtag_tap_pkg.sv
hdl/tap_state_decoder.sv
hdl/tap_scan_registers.sv
hdl/tap_scan_output.sv
hdl/jtag_tap_top.sv
verification/jtag_tap_assertions.sv
verification/jtag_tap_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the JTAG TAP testbench with Verilator, run it, search for the pass line
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module jtag_tap_tb \
    -f tb.f

# output goes to the terminal and to the search
if ./obj_dir/Vjtag_tap_tb | tee /dev/stderr | grep -x "Verification passed" > /dev/null
then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation failed"
    exit 1
fi

/* verification/jtag_tap_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the JTAG TAP, directed and random scans vs a model
// top module jtag_tap_tb, assertion checks are bound into the DUT
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "jtag_tap_consts.svh"

module jtag_tap_tb import jtag_tap_pkg::*;
();

    logic                  jtag_clk;
    logic                  sys_rst_n;
    logic                  jtag_tms;
    logic                  jtag_tdi;
    logic                  jtag_tdo;
    logic [`LED_WIDTH-1:0] led;

    // reference model state and registers
    tap_state_e             model_state;
    logic [`SCAN_WIDTH-1:0] model_ir_chain;
    logic [`SCAN_WIDTH-1:0] model_dr_chain;
    logic [`SCAN_WIDTH-1:0] model_ir;
    logic [`SCAN_WIDTH-1:0] model_idcode;
    logic [`SCAN_WIDTH-1:0] model_custom;

    logic last_tdo;
    int   errors;
    int   tests_run;
    int   tests_failed;

    jtag_tap_top dut_i (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .jtag_tms  (jtag_tms),
        .jtag_tdi  (jtag_tdi),
        .jtag_tdo  (jtag_tdo),
        .led       (led)
    );

    bind jtag_tap_top jtag_tap_assertions assertions_i (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .state     (state),
        .jtag_tdo  (jtag_tdo),
        .led       (led)
    );

    initial
    begin
        jtag_clk = 1'b0;
        forever #10 jtag_clk = ~jtag_clk;
    end

    // standard TAP transitions
    function automatic tap_state_e next_state(input tap_state_e s, input logic tms);
        case (s)
            TEST_LOGIC_RESET: return tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   return tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:       return tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:         return tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:         return tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:         return tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:         return tms ? UPDATE_DR : SHIFT_DR;
            SELECT_IR_SCAN:   return tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       return tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:         return tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:         return tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:         return tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:         return tms ? UPDATE_IR : SHIFT_IR;
            // both update states
            default:          return tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
        endcase
    endfunction

    // one model edge, action of the state being left
    function automatic void model_clock(input logic tms, input logic tdi);
        case (model_state)
            TEST_LOGIC_RESET: model_ir = `IDCODE_INSTR;
            CAPTURE_IR:       model_ir_chain = model_ir;
            SHIFT_IR:         model_ir_chain = {tdi, model_ir_chain[`SCAN_WIDTH-1:1]};
            UPDATE_IR:        model_ir = model_ir_chain;
            // unknown instruction reads zero
            CAPTURE_DR:       model_dr_chain = (model_ir == `IDCODE_INSTR) ? model_idcode :
                                  (model_ir == `CUSTOM1_INSTR) ? model_custom : '0;
            SHIFT_DR:         model_dr_chain = {tdi, model_dr_chain[`SCAN_WIDTH-1:1]};
            UPDATE_DR:
            begin
                if (model_ir == `IDCODE_INSTR)
                    model_idcode = model_dr_chain;
                else if (model_ir == `CUSTOM1_INSTR)
                    model_custom = model_dr_chain;
            end
            default: ;
        endcase
        model_state = next_state(model_state, tms);
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
        errors++;
        $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, got);
    endtask

    // one TAP cycle, entered 2 ns after a rising edge
    task automatic step(input logic tms, input logic tdi);
        logic [`LED_WIDTH-1:0] exp_led;
        logic                  exp_tdo;
        jtag_tms = tms;
        jtag_tdi = tdi;
        // inverted state code, ones above it
        exp_led  = {{(`LED_WIDTH-`STATE_WIDTH){1'b1}}, ~model_state};
        exp_tdo  = (model_state == SHIFT_IR) ? model_ir_chain[0] :
                   (model_state == SHIFT_DR) ? model_dr_chain[0] : 1'b0;
        // late in the cycle, TDO was launched at the falling edge
        #15;
        if (led !== exp_led)
            flag_mismatch("led", 32'(exp_led), 32'(led));
        if (jtag_tdo !== exp_tdo)
            flag_mismatch("jtag_tdo", 32'(exp_tdo), 32'(jtag_tdo));
        last_tdo = jtag_tdo;
        @(posedge jtag_clk);
        model_clock(tms, tdi);
        #2;
    endtask

    // hold TMS until the LEDs show the target state
    task automatic wait_state(input tap_state_e target, input logic tms);
        logic [`LED_WIDTH-1:0] target_led;
        int                    count;
        target_led = {{(`LED_WIDTH-`STATE_WIDTH){1'b1}}, ~target};
        count      = 0;
        while (led !== target_led && count < 16)
        begin
            step(tms, 1'b0);
            count++;
        end
        if (led !== target_led)
        begin
            $display("timeout, the TAP never reached state %s", target.name());
            $display("Verification failed");
            $finish;
        end
    endtask

    // full scan from idle back to idle, optionally through PAUSE and EXIT2
    task automatic scan(input logic is_ir, input logic [`SCAN_WIDTH-1:0] data_in,
                        input logic via_pause, output logic [`SCAN_WIDTH-1:0] data_out);
        logic [`SCAN_WIDTH-1:0] shift_in;
        shift_in = data_in;
        data_out = '0;
        step(1'b1, 1'b0);
        if (is_ir)
            step(1'b1, 1'b0);
        wait_state(is_ir ? SHIFT_IR : SHIFT_DR, 1'b0);
        for (int i = 0; i < `SCAN_WIDTH; i++)
        begin
            // last bit leaves for EXIT1, LSB first out
            step(i == `SCAN_WIDTH - 1, shift_in[0]);
            shift_in = shift_in >> 1;
            data_out = {last_tdo, data_out[`SCAN_WIDTH-1:1]};
        end
        if (via_pause)
        begin
            step(1'b0, 1'b0);
            step(1'b0, 1'b0);
            step(1'b1, 1'b0);
        end
        step(1'b1, 1'b0);
        step(1'b0, 1'b0);
    endtask

    task automatic apply_reset();
        sys_rst_n = 1'b0;
        jtag_tms  = 1'b1;
        jtag_tdi  = 1'b0;
        repeat (2) @(posedge jtag_clk);
        #2;
        sys_rst_n      = 1'b1;
        model_state    = TEST_LOGIC_RESET;
        model_ir       = `IDCODE_INSTR;
        model_idcode   = `JTAG_ID_VALUE;
        model_custom   = `CUSTOM1_RESET_VALUE;
        model_ir_chain = '0;
        model_dr_chain = '0;
    endtask

    task automatic close_test(input string name, input int base);
        tests_run++;
        if (errors == base)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - base);
        end
    endtask

    initial
    begin
        int                     base;
        logic [`SCAN_WIDTH-1:0] word;
        logic [`SCAN_WIDTH-1:0] value;
        logic [`SCAN_WIDTH-1:0] unknown;
        sys_rst_n    = 1'b0;
        jtag_tms     = 1'b1;
        jtag_tdi     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(75235));
        apply_reset();

        // LEDs dark in reset, IDCODE sits in the IR
        base = errors;
        if (led !== {`LED_WIDTH{1'b1}})
            flag_mismatch("led", 32'h3f, 32'(led));
        step(1'b0, 1'b0);
        scan(1'b1, `IDCODE_INSTR, 1'b0, word);
        if (word !== `IDCODE_INSTR)
            flag_mismatch("ir scan out", `IDCODE_INSTR, word);
        close_test("reset and IR scan", base);

        // random walk, covers the idle and pause self-loops
        base = errors;
        repeat (2000) step(1'($urandom), 1'($urandom));
        close_test("random TMS walk", base);

        // ID code shifted out, same value shifted back in
        apply_reset();
        base = errors;
        step(1'b0, 1'b0);
        scan(1'b0, `JTAG_ID_VALUE, 1'b0, word);
        if (word !== `JTAG_ID_VALUE)
            flag_mismatch("idcode dr scan", `JTAG_ID_VALUE, word);
        close_test("IDCODE DR scan", base);

        base = errors;
        scan(1'b1, `CUSTOM1_INSTR, 1'b0, word);
        scan(1'b0, `CUSTOM1_RESET_VALUE, 1'b0, word);
        if (word !== `CUSTOM1_RESET_VALUE)
            flag_mismatch("custom dr scan", `CUSTOM1_RESET_VALUE, word);
        scan(1'b1, `CUSTOM1_INSTR, 1'b0, word);
        if (word !== `CUSTOM1_INSTR)
            flag_mismatch("ir scan out", `CUSTOM1_INSTR, word);
        close_test("custom instruction", base);

        // update through EXIT1, then through PAUSE and EXIT2
        base = errors;
        for (int path = 0; path < 2; path++)
        begin
            value = $urandom();
            scan(1'b0, value, path[0], word);
            scan(1'b0, value, 1'b0, word);
            if (word !== value)
                flag_mismatch("custom readback", value, word);
        end
        // bits 31 and 0 cleared, matches neither known code
        unknown = $urandom() & 32'h7fff_fffe;
        scan(1'b1, unknown, 1'b0, word);
        scan(1'b0, $urandom(), 1'b0, word);
        if (word !== '0)
            flag_mismatch("unknown dr scan", '0, word);
        scan(1'b1, `IDCODE_INSTR, 1'b0, word);
        scan(1'b0, `JTAG_ID_VALUE, 1'b0, word);
        if (word !== `JTAG_ID_VALUE)
            flag_mismatch("idcode after unknown", `JTAG_ID_VALUE, word);
        scan(1'b1, `CUSTOM1_INSTR, 1'b0, word);
        scan(1'b0, value, 1'b0, word);
        if (word !== value)
            flag_mismatch("custom after unknown", value, word);
        close_test("update paths and unknown instruction", base);

        // TMS biased low for longer shifts, reset trips now and then
        base = errors;
        for (int n = 0; n < 4000; n++)
        begin
            if ($urandom_range(199) == 0)
                repeat (5) step(1'b1, 1'($urandom));
            step($urandom_range(3) == 0, 1'($urandom));
        end
        close_test("random TMS and TDI with resets", base);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/jtag_tap_assertions.sv */
//////////////////////////////////////////////////////////////////////
// concurrent checks on the LED display and the TDO idle level
// bound into the TAP top level from the testbench
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "jtag_tap_consts.svh"

module jtag_tap_assertions import jtag_tap_pkg::*;
(
    input logic                  jtag_clk,
    input logic                  sys_rst_n,
    input tap_state_e            state,
    input logic                  jtag_tdo,
    input logic [`LED_WIDTH-1:0] led
);

    logic in_shift;

    assign in_shift = (state == SHIFT_DR) || (state == SHIFT_IR);

    // no state bit behind the top LEDs
    led_upper_dark: assert property (
        @(posedge jtag_clk) disable iff (!sys_rst_n)
        led[`LED_WIDTH-1:`STATE_WIDTH] == '1
    ) else $error("upper LED bits are not all ones");

    // TDO launches on the falling edge, so check there
    tdo_idle_low: assert property (
        @(negedge jtag_clk) disable iff (!sys_rst_n)
        !in_shift |=> (jtag_tdo == 1'b0)
    ) else $error("jtag_tdo not low after a non-shift state");

    // low LED bits carry the inverted state code
    led_shows_state: assert property (
        @(posedge jtag_clk) disable iff (!sys_rst_n)
        led == {{(`LED_WIDTH-`STATE_WIDTH){1'b1}}, ~state}
    ) else $error("led does not match the inverted state code");

endmodule

`default_nettype wire

/* hdl/jtag_tap_top.sv */
//////////////////////////////////////////////////////////////////////
// JTAG TAP top, decode then scan registers then TDO and LED output
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "jtag_tap_consts.svh"

module jtag_tap_top import jtag_tap_pkg::*;
(
    input  logic                  jtag_clk,
    input  logic                  sys_rst_n,
    input  logic                  jtag_tms,
    input  logic                  jtag_tdi,
    output logic                  jtag_tdo,
    output logic [`LED_WIDTH-1:0] led
);

    // decode stage outputs
    tap_state_e state;
    scan_op_e   scan_op;

    // execute stage outputs
    logic shift_bit;
    logic shift_active;

    // TAP FSM and state decode
    tap_state_decoder decoder_i (
        .jtag_clk  (jtag_clk),
        .sys_rst_n (sys_rst_n),
        .jtag_tms  (jtag_tms),
        .state     (state),
        .scan_op   (scan_op)
    );

    // IR and DR chains
    tap_scan_registers registers_i (
        .jtag_clk     (jtag_clk),
        .sys_rst_n    (sys_rst_n),
        .jtag_tdi     (jtag_tdi),
        .scan_op      (scan_op),
        .shift_bit    (shift_bit),
        .shift_active (shift_active)
    );

    // TDO and LED drive
    tap_scan_output output_i (
        .jtag_clk     (jtag_clk),
        .shift_bit    (shift_bit),
        .shift_active (shift_active),
        .state        (state),
        .jtag_tdo     (jtag_tdo),
        .led          (led)
    );

endmodule

`default_nettype wire

/* hdl/tap_scan_output.sv */
//////////////////////////////////////////////////////////////////////
// TDO launch on the falling edge and the inverted LED state display
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "jtag_tap_consts.svh"

module tap_scan_output import jtag_tap_pkg::*;
(
    input  logic                  jtag_clk,
    input  logic                  shift_bit,
    input  logic                  shift_active,
    input  tap_state_e            state,
    output logic                  jtag_tdo,
    output logic [`LED_WIDTH-1:0] led
);

    // zero pad for the LED bits above the state code
    localparam int LED_PAD = `LED_WIDTH - `STATE_WIDTH;

    // TDO changes on the falling edge, host samples on the rising edge
    // idle level is 0 outside shift states
    always_ff @(negedge jtag_clk)
    begin
        if (shift_active)
        begin
            jtag_tdo <= shift_bit;
        end
        else
        begin
            jtag_tdo <= 1'b0;
        end
    end

    // LEDs are active low, so a lit LED marks a 1 in the state code
    // unused upper LEDs stay dark
    assign led = ~{{LED_PAD{1'b0}}, state};

endmodule

`default_nettype wire

/* hdl/tap_scan_registers.sv */
//////////////////////////////////////////////////////////////////////
// IR and DR scan chains plus the IDCODE and custom data registers
// capture, shift and update follow the scan op from the decoder
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "jtag_tap_consts.svh"

module tap_scan_registers import jtag_tap_pkg::*;
(
    input  logic     jtag_clk,
    input  logic     sys_rst_n,
    input  logic     jtag_tdi,
    input  scan_op_e scan_op,
    output logic     shift_bit,
    output logic     shift_active
);

    // shift chains
    logic [`SCAN_WIDTH-1:0] ir_chain;
    logic [`SCAN_WIDTH-1:0] dr_chain;

    // parallel registers
    logic [`SCAN_WIDTH-1:0] ir_reg;
    logic [`SCAN_WIDTH-1:0] idcode_reg;
    logic [`SCAN_WIDTH-1:0] custom1_reg;

    // data register select from the current instruction
    logic sel_idcode;
    logic sel_custom1;

    assign sel_idcode  = (ir_reg == `IDCODE_INSTR);
    assign sel_custom1 = (ir_reg == `CUSTOM1_INSTR);

    // chains, LSB leaves first, TDI enters at the top
    always_ff @(posedge jtag_clk)
    begin
        case (scan_op)
            OP_CAPTURE_IR:
            begin
                ir_chain <= ir_reg;
            end
            OP_SHIFT_IR:
            begin
                ir_chain <= {jtag_tdi, ir_chain[`SCAN_WIDTH-1:1]};
            end
            OP_CAPTURE_DR:
            begin
                // unknown instruction captures zero
                if (sel_idcode)
                begin
                    dr_chain <= idcode_reg;
                end
                else if (sel_custom1)
                begin
                    dr_chain <= custom1_reg;
                end
                else
                begin
                    dr_chain <= '0;
                end
            end
            OP_SHIFT_DR:
            begin
                dr_chain <= {jtag_tdi, dr_chain[`SCAN_WIDTH-1:1]};
            end
            default:
            begin
                // chains hold
            end
        endcase
    end

    // instruction and data registers
    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            ir_reg      <= `IDCODE_INSTR;
            idcode_reg  <= `JTAG_ID_VALUE;
            custom1_reg <= `CUSTOM1_RESET_VALUE;
        end
        else
        begin
            case (scan_op)
                OP_RESET:
                begin
                    // test-logic-reset reselects IDCODE
                    ir_reg <= `IDCODE_INSTR;
                end
                OP_UPDATE_IR:
                begin
                    ir_reg <= ir_chain;
                end
                OP_UPDATE_DR:
                begin
                    // reached from either exit state
                    if (sel_idcode)
                    begin
                        idcode_reg <= dr_chain;
                    end
                    else if (sel_custom1)
                    begin
                        custom1_reg <= dr_chain;
                    end
                end
                default:
                begin
                    // registers hold
                end
            endcase
        end
    end

    // bit under the TDO driver, valid in shift states only
    assign shift_active = (scan_op == OP_SHIFT_IR) || (scan_op == OP_SHIFT_DR);
    assign shift_bit    = (scan_op == OP_SHIFT_IR) ? ir_chain[0] : dr_chain[0];

endmodule

`default_nettype wire

/* hdl/tap_state_decoder.sv */
//////////////////////////////////////////////////////////////////////
// TAP controller FSM driven by TMS, decodes the state into a scan op
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tap_state_decoder import jtag_tap_pkg::*;
(
    input  logic       jtag_clk,
    input  logic       sys_rst_n,
    input  logic       jtag_tms,
    output tap_state_e state,
    output scan_op_e   scan_op
);

    tap_state_e state_next;

    // state register, TMS sampled on the rising edge
    always_ff @(posedge jtag_clk)
    begin
        if (!sys_rst_n)
        begin
            state <= TEST_LOGIC_RESET;
        end
        else
        begin
            state <= state_next;
        end
    end

    // next-state table
    always_comb
    begin
        state_next = state;
        unique case (state)
            TEST_LOGIC_RESET:
                state_next = jtag_tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:
                state_next = jtag_tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            // DR column
            SELECT_DR_SCAN:
                state_next = jtag_tms ? SELECT_IR_SCAN : CAPTURE_DR;
            CAPTURE_DR:
                state_next = jtag_tms ? EXIT1_DR : SHIFT_DR;
            SHIFT_DR:
                state_next = jtag_tms ? EXIT1_DR : SHIFT_DR;
            EXIT1_DR:
                state_next = jtag_tms ? UPDATE_DR : PAUSE_DR;
            PAUSE_DR:
                state_next = jtag_tms ? EXIT2_DR : PAUSE_DR;
            EXIT2_DR:
                state_next = jtag_tms ? UPDATE_DR : SHIFT_DR;
            UPDATE_DR:
                state_next = jtag_tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
            // IR column
            SELECT_IR_SCAN:
                state_next = jtag_tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:
                state_next = jtag_tms ? EXIT1_IR : SHIFT_IR;
            SHIFT_IR:
                state_next = jtag_tms ? EXIT1_IR : SHIFT_IR;
            EXIT1_IR:
                state_next = jtag_tms ? UPDATE_IR : PAUSE_IR;
            PAUSE_IR:
                state_next = jtag_tms ? EXIT2_IR : PAUSE_IR;
            EXIT2_IR:
                state_next = jtag_tms ? UPDATE_IR : SHIFT_IR;
            UPDATE_IR:
                state_next = jtag_tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
        endcase
    end

    // scan op straight from the current state
    // the action lands on the rising edge that leaves the state
    always_comb
    begin
        case (state)
            TEST_LOGIC_RESET: scan_op = OP_RESET;
            CAPTURE_IR:       scan_op = OP_CAPTURE_IR;
            SHIFT_IR:         scan_op = OP_SHIFT_IR;
            UPDATE_IR:        scan_op = OP_UPDATE_IR;
            CAPTURE_DR:       scan_op = OP_CAPTURE_DR;
            SHIFT_DR:         scan_op = OP_SHIFT_DR;
            UPDATE_DR:        scan_op = OP_UPDATE_DR;
            // select, exit, pause and idle states do nothing
            default:          scan_op = OP_NONE;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/jtag_tap_pkg.sv */
//////////////////////////////////////////////////////////////////////
// TAP state and scan operation types, shared by all stages
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "jtag_tap_consts.svh"

package jtag_tap_pkg;

    // sixteen TAP states, codes follow the board LED encoding
    typedef enum logic [`STATE_WIDTH-1:0] {
        TEST_LOGIC_RESET = 4'd0,
        RUN_TEST_IDLE    = 4'd1,
        // DR column
        SELECT_DR_SCAN   = 4'd2,
        CAPTURE_DR       = 4'd3,
        SHIFT_DR         = 4'd4,
        EXIT1_DR         = 4'd5,
        PAUSE_DR         = 4'd6,
        EXIT2_DR         = 4'd7,
        UPDATE_DR        = 4'd8,
        // IR column
        SELECT_IR_SCAN   = 4'd9,
        CAPTURE_IR       = 4'd10,
        SHIFT_IR         = 4'd11,
        EXIT1_IR         = 4'd12,
        PAUSE_IR         = 4'd13,
        EXIT2_IR         = 4'd14,
        UPDATE_IR        = 4'd15
    } tap_state_e;

    // action the scan registers take in the current state
    typedef enum logic [2:0] {
        OP_NONE       = 3'd0,
        OP_RESET      = 3'd1,
        OP_CAPTURE_IR = 3'd2,
        OP_SHIFT_IR   = 3'd3,
        OP_UPDATE_IR  = 3'd4,
        OP_CAPTURE_DR = 3'd5,
        OP_SHIFT_DR   = 3'd6,
        OP_UPDATE_DR  = 3'd7
    } scan_op_e;

endpackage

`default_nettype wire

/* hdl/jtag_tap_consts.svh */
//////////////////////////////////////////////////////////////////////
// widths, instruction codes and reset values of the JTAG TAP
// include wherever a width or code is needed
//////////////////////////////////////////////////////////////////////
`ifndef JTAG_TAP_CONSTS_SVH
`define JTAG_TAP_CONSTS_SVH

// scan chain and register width, one word
`define SCAN_WIDTH 32

// TAP state code width
`define STATE_WIDTH 4

// number of board LEDs
`define LED_WIDTH 6

// instruction codes
`define IDCODE_INSTR 32'hFFFF_FFFF
`define CUSTOM1_INSTR 32'h0A0B_0C0D

// data register reset values
`define JTAG_ID_VALUE 32'h1234_5678
`define CUSTOM1_RESET_VALUE 32'h0A0B_0C0D

`endif
